//--- frontEndPkg.sv
package frontEndPkg;

    // instruction buffer geometry
    localparam int IB_SIZE = 16;
    localparam int IB_ADDR_W = 4;

    // fill level at or below which a held pause is dropped
    localparam int PAUSE_RELEASE = 8;

    // datapath widths
    localparam int INST_W = 32;
    localparam int PC_W = 32;
    // one aligned instruction pair per bus beat
    localparam int WB_DATA_W = 64;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM = 6'h01;
    localparam logic [5:0] OP_J = 6'h02;
    localparam logic [5:0] OP_JAL = 6'h03;
    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_BNE = 6'h05;
    localparam logic [5:0] OP_BLEZ = 6'h06;
    localparam logic [5:0] OP_BGTZ = 6'h07;

    // function codes under OP_SPECIAL, inst[5:0]
    localparam logic [5:0] FN_JR = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;

endpackage

//--- preDecode.sv
`timescale 1ns/1ns

module preDecode import frontEndPkg::*; (
    input  logic [INST_W-1:0] inst,
    output logic              isBr,
    output logic              isJ
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;

    assign opcode = inst[31:26];
    assign rt = inst[20:16];
    assign funct = inst[5:0];

    always_comb begin
        isBr = 1'b0;
        isJ = 1'b0;
        case (opcode)
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                isBr = 1'b1;
            end
            OP_REGIMM: begin
                // bltz, bgez, bltzal, bgezal live at rt 0, 1, 16, 17
                isBr = (rt[3:1] == 3'b000);
            end
            OP_J, OP_JAL: begin
                isJ = 1'b1;
            end
            OP_SPECIAL: begin
                // register jumps
                isJ = (funct == FN_JR) || (funct == FN_JALR);
            end
            default: begin
                isBr = 1'b0;
                isJ = 1'b0;
            end
        endcase
    end

endmodule

//--- fetchUnit.sv
`timescale 1ns/1ns

module fetchUnit import frontEndPkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 pauseReq,
    input  logic                 flush,
    input  logic [PC_W-1:0]      redirectPc,

    // wishbone classic master
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic [PC_W-1:0]      wbAdr,
    input  logic                 wbAck,
    input  logic [WB_DATA_W-1:0] wbDatIn,

    // fetched pair toward the instruction buffer
    output logic                 fetchValid0,
    output logic                 fetchValid1,
    output logic [INST_W-1:0]    fetchInst0,
    output logic [INST_W-1:0]    fetchInst1,
    output logic [PC_W-1:0]      fetchPc0,
    output logic [PC_W-1:0]      fetchPc1,
    output logic                 fetchIsBr0,
    output logic                 fetchIsJ0,
    output logic                 fetchIsBr1,
    output logic                 fetchIsJ1
);

    // next pc to fetch
    logic [PC_W-1:0] pc;
    // pc of the bus cycle in flight
    logic [PC_W-1:0] reqPc;
    logic            busy;
    // open cycle was overtaken by a flush
    logic            stale;
    logic            hit;
    logic            upperOnly;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            busy <= 1'b0;
            stale <= 1'b0;
        end else if (busy) begin
            if (wbAck) begin
                busy <= 1'b0;
                stale <= 1'b0;
                if (flush) begin
                    pc <= redirectPc;
                end else if (!stale) begin
                    // continue at the next pair boundary
                    pc <= {reqPc[PC_W-1:3] + 1'b1, 3'b000};
                end
            end else if (flush) begin
                // finish the open cycle and drop its data later
                stale <= 1'b1;
                pc <= redirectPc;
            end
        end else if (flush) begin
            pc <= redirectPc;
        end else if (!pauseReq) begin
            busy <= 1'b1;
        end
    end

    // latched at cycle start so the address holds until ack
    always_ff @(posedge clk) begin
        if (!busy && !flush && !pauseReq) begin
            reqPc <= pc;
        end
    end

    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbAdr = {reqPc[PC_W-1:3], 3'b000};

    // a pair arriving in the flush cycle is stale as well
    assign hit = busy && wbAck && !stale && !flush;
    assign upperOnly = reqPc[2];

    assign fetchValid0 = hit && !upperOnly;
    assign fetchValid1 = hit;
    assign fetchInst0 = wbDatIn[INST_W-1:0];
    assign fetchInst1 = wbDatIn[WB_DATA_W-1:INST_W];
    assign fetchPc0 = {reqPc[PC_W-1:3], 3'b000};
    assign fetchPc1 = {reqPc[PC_W-1:3], 3'b100};

    preDecode decode0 (
        .inst (fetchInst0),
        .isBr (fetchIsBr0),
        .isJ  (fetchIsJ0)
    );

    preDecode decode1 (
        .inst (fetchInst1),
        .isBr (fetchIsBr1),
        .isJ  (fetchIsJ1)
    );

    // bus protocol checks
    assert property (@(posedge clk) disable iff (rst) wbAck |-> wbCyc)
        else $error("wbAck outside an open bus cycle");

    assert property (@(posedge clk) disable iff (rst)
        (wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr)))
        else $error("wbAdr changed while waiting for ack");

endmodule

//--- instBuffer.sv
`timescale 1ns/1ns

module instBuffer import frontEndPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,

    // fetched pair
    input  logic              fetchValid0,
    input  logic              fetchValid1,
    input  logic [INST_W-1:0] fetchInst0,
    input  logic [INST_W-1:0] fetchInst1,
    input  logic [PC_W-1:0]   fetchPc0,
    input  logic [PC_W-1:0]   fetchPc1,
    input  logic              fetchIsBr0,
    input  logic              fetchIsJ0,
    input  logic              fetchIsBr1,
    input  logic              fetchIsJ1,
    output logic              pauseReq,

    // issue port toward the backend
    output logic              issueValid,
    input  logic              issueReady,
    output logic [INST_W-1:0] issueInst0,
    output logic [PC_W-1:0]   issuePc0,
    output logic              issueValid0,
    output logic [INST_W-1:0] issueInst1,
    output logic [PC_W-1:0]   issuePc1,
    output logic              issueValid1,
    output logic              issueIsDs1
);

    logic [INST_W-1:0]    memInst [IB_SIZE];
    logic [PC_W-1:0]      memPc [IB_SIZE];
    logic                 memBr [IB_SIZE];
    logic                 memJ [IB_SIZE];

    // one extra wrap bit on each pointer
    logic [IB_ADDR_W:0]   head;
    logic [IB_ADDR_W:0]   tail;
    logic [IB_ADDR_W:0]   fill;
    logic [IB_ADDR_W:0]   free;
    logic [IB_ADDR_W-1:0] rd0;
    logic [IB_ADDR_W-1:0] rd1;
    logic [IB_ADDR_W-1:0] wr0;
    logic [IB_ADDR_W-1:0] wr1;

    logic                 empty;
    logic                 loaded1;
    logic                 ctl0;
    logic                 ctl1;
    logic                 waitForDs;
    logic                 passThrough;
    logic                 dual;
    logic                 full;
    logic                 needPause;

    logic                 wrEn;
    logic [1:0]           wrCount;
    logic [INST_W-1:0]    firstInst;
    logic [PC_W-1:0]      firstPc;
    logic                 firstBr;
    logic                 firstJ;

    assign fill = tail - head;
    assign free = (IB_ADDR_W+1)'(IB_SIZE) - fill;
    assign empty = (fill == '0);
    assign loaded1 = (fill >= (IB_ADDR_W+1)'(2));

    assign rd0 = head[IB_ADDR_W-1:0];
    assign rd1 = rd0 + IB_ADDR_W'(1);
    assign wr0 = tail[IB_ADDR_W-1:0];
    assign wr1 = wr0 + IB_ADDR_W'(1);

    // pause with hysteresis keeps room for one pair in flight
    assign full = (free <= (IB_ADDR_W+1)'(2));
    assign pauseReq = full || needPause;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            needPause <= 1'b0;
        end else if (full) begin
            needPause <= 1'b1;
        end else if (fill <= (IB_ADDR_W+1)'(PAUSE_RELEASE)) begin
            needPause <= 1'b0;
        end
    end

    // a safe full pair skips the ring when nothing is queued
    assign passThrough = empty && issueReady && fetchValid0 && fetchValid1 &&
                         !fetchIsBr1 && !fetchIsJ1 && !flush;

    assign ctl0 = passThrough ? (fetchIsBr0 || fetchIsJ0) : (memBr[rd0] || memJ[rd0]);
    assign ctl1 = memBr[rd1] || memJ[rd1];

    // branch at head with its delay slot still missing
    assign waitForDs = !passThrough && !loaded1 && ctl0;

    assign dual = passThrough || (loaded1 && !ctl1);

    assign issueValid = !flush && (passThrough || (!empty && !waitForDs));
    assign issueValid0 = issueValid;
    assign issueValid1 = issueValid && dual;
    assign issueIsDs1 = issueValid1 && ctl0;

    always_comb begin
        if (passThrough) begin
            issueInst0 = fetchInst0;
            issuePc0 = fetchPc0;
            issueInst1 = fetchInst1;
            issuePc1 = fetchPc1;
        end else begin
            issueInst0 = memInst[rd0];
            issuePc0 = memPc[rd0];
            issueInst1 = memInst[rd1];
            issuePc1 = memPc[rd1];
        end
    end

    // a lone upper word lands in the first free entry
    assign wrEn = !flush && !passThrough && (fetchValid0 || fetchValid1);
    assign wrCount = {1'b0, fetchValid0} + {1'b0, fetchValid1};
    assign firstInst = fetchValid0 ? fetchInst0 : fetchInst1;
    assign firstPc = fetchValid0 ? fetchPc0 : fetchPc1;
    assign firstBr = fetchValid0 ? fetchIsBr0 : fetchIsBr1;
    assign firstJ = fetchValid0 ? fetchIsJ0 : fetchIsJ1;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            memInst[wr0] <= firstInst;
            memPc[wr0] <= firstPc;
            memBr[wr0] <= firstBr;
            memJ[wr0] <= firstJ;
            if (wrCount == 2'd2) begin
                memInst[wr1] <= fetchInst1;
                memPc[wr1] <= fetchPc1;
                memBr[wr1] <= fetchIsBr1;
                memJ[wr1] <= fetchIsJ1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (wrEn) begin
                tail <= tail + (IB_ADDR_W+1)'(wrCount);
            end
            if (issueValid && issueReady && !passThrough) begin
                head <= head + (issueValid1 ? (IB_ADDR_W+1)'(2) : (IB_ADDR_W+1)'(1));
            end
        end
    end

    // fetch honours pauseReq so a write always fits
    assert property (@(posedge clk) disable iff (rst)
        wrEn |-> ((IB_ADDR_W+1)'(wrCount) <= free))
        else $error("write of %0d words with only %0d free", wrCount, free);

    // slot 1 always carries the word after slot 0
    assert property (@(posedge clk) disable iff (rst)
        issueValid1 |-> (issuePc1 == issuePc0 + PC_W'(4)))
        else $error("slot 1 pc %h does not follow slot 0 pc %h", issuePc1, issuePc0);

endmodule

//--- frontEnd.sv
`timescale 1ns/1ns

module frontEnd import frontEndPkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // instruction memory, wishbone classic
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic [PC_W-1:0]      wbAdr,
    input  logic                 wbAck,
    input  logic [WB_DATA_W-1:0] wbDatIn,

    // backend control
    input  logic                 flush,
    input  logic [PC_W-1:0]      redirectPc,

    // issue port
    output logic                 issueValid,
    input  logic                 issueReady,
    output logic [INST_W-1:0]    issueInst0,
    output logic [PC_W-1:0]      issuePc0,
    output logic                 issueValid0,
    output logic [INST_W-1:0]    issueInst1,
    output logic [PC_W-1:0]      issuePc1,
    output logic                 issueValid1,
    output logic                 issueIsDs1
);

    logic              pauseReq;
    logic              fetchValid0;
    logic              fetchValid1;
    logic [INST_W-1:0] fetchInst0;
    logic [INST_W-1:0] fetchInst1;
    logic [PC_W-1:0]   fetchPc0;
    logic [PC_W-1:0]   fetchPc1;
    logic              fetchIsBr0;
    logic              fetchIsJ0;
    logic              fetchIsBr1;
    logic              fetchIsJ1;

    fetchUnit fetch (
        .clk         (clk),
        .rst         (rst),
        .pauseReq    (pauseReq),
        .flush       (flush),
        .redirectPc  (redirectPc),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbAdr       (wbAdr),
        .wbAck       (wbAck),
        .wbDatIn     (wbDatIn),
        .fetchValid0 (fetchValid0),
        .fetchValid1 (fetchValid1),
        .fetchInst0  (fetchInst0),
        .fetchInst1  (fetchInst1),
        .fetchPc0    (fetchPc0),
        .fetchPc1    (fetchPc1),
        .fetchIsBr0  (fetchIsBr0),
        .fetchIsJ0   (fetchIsJ0),
        .fetchIsBr1  (fetchIsBr1),
        .fetchIsJ1   (fetchIsJ1)
    );

    instBuffer buffer (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .fetchValid0 (fetchValid0),
        .fetchValid1 (fetchValid1),
        .fetchInst0  (fetchInst0),
        .fetchInst1  (fetchInst1),
        .fetchPc0    (fetchPc0),
        .fetchPc1    (fetchPc1),
        .fetchIsBr0  (fetchIsBr0),
        .fetchIsJ0   (fetchIsJ0),
        .fetchIsBr1  (fetchIsBr1),
        .fetchIsJ1   (fetchIsJ1),
        .pauseReq    (pauseReq),
        .issueValid  (issueValid),
        .issueReady  (issueReady),
        .issueInst0  (issueInst0),
        .issuePc0    (issuePc0),
        .issueValid0 (issueValid0),
        .issueInst1  (issueInst1),
        .issuePc1    (issuePc1),
        .issueValid1 (issueValid1),
        .issueIsDs1  (issueIsDs1)
    );

endmodule

//--- frontEnd_tb.sv
`timescale 1ns/1ns

module frontEnd_tb import frontEndPkg::*; ();

    logic                 clk;
    logic                 rst;
    logic                 wbCyc;
    logic                 wbStb;
    logic [PC_W-1:0]      wbAdr;
    logic                 wbAck;
    logic [WB_DATA_W-1:0] wbDatIn;
    logic                 flush;
    logic [PC_W-1:0]      redirectPc;
    logic                 issueValid;
    logic                 issueReady;
    logic [INST_W-1:0]    issueInst0;
    logic [PC_W-1:0]      issuePc0;
    logic                 issueValid0;
    logic [INST_W-1:0]    issueInst1;
    logic [PC_W-1:0]      issuePc1;
    logic                 issueValid1;
    logic                 issueIsDs1;

    typedef struct {
        logic [PC_W-1:0] startPc;
        int              count;
        int              readyPct;
        bit              holdReady;
        bit              endFlush;
    } testRow;

    logic [INST_W-1:0] prog [64];
    testRow            rows [5];
    integer            seed;
    int                errors;
    int                consumed;
    logic [PC_W-1:0]   expPc;
    logic [1:0]        waitLeft;
    logic              busWait;
    logic [PC_W-1:0]   lastAdr;
    int                r;

    frontEnd dut (
        .clk         (clk),
        .rst         (rst),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbAdr       (wbAdr),
        .wbAck       (wbAck),
        .wbDatIn     (wbDatIn),
        .flush       (flush),
        .redirectPc  (redirectPc),
        .issueValid  (issueValid),
        .issueReady  (issueReady),
        .issueInst0  (issueInst0),
        .issuePc0    (issuePc0),
        .issueValid0 (issueValid0),
        .issueInst1  (issueInst1),
        .issuePc1    (issuePc1),
        .issueValid1 (issueValid1),
        .issueIsDs1  (issueIsDs1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // wishbone slave with 0 to 3 wait states over a 64 word image
    always @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
            waitLeft <= 2'd0;
        end else if (wbAck) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (waitLeft == 2'd0) begin
                wbAck <= 1'b1;
                wbDatIn <= {prog[{wbAdr[7:3], 1'b1}], prog[{wbAdr[7:3], 1'b0}]};
                waitLeft <= 2'($unsigned($random(seed)) % 4);
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

    // master side of the bus as the slave sees it
    always @(negedge clk) begin
        if (!rst) begin
            if (wbStb !== wbCyc) begin
                $display("wbStb and wbCyc differ");
                errors++;
            end
            if (busWait && (!wbCyc || wbAdr !== lastAdr)) begin
                $display("bus cycle changed before wbAck");
                errors++;
            end
        end
        busWait = wbCyc && !wbAck;
        lastAdr = wbAdr;
    end

    // branch or jump per the MIPS opcode map
    function automatic logic isCtl(input logic [INST_W-1:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op == OP_BEQ || op == OP_BNE || op == OP_BLEZ || op == OP_BGTZ) begin
            return 1'b1;
        end
        if (op == OP_J || op == OP_JAL) begin
            return 1'b1;
        end
        if (op == OP_REGIMM) begin
            return (w[20:16] == 5'd0) || (w[20:16] == 5'd1) ||
                   (w[20:16] == 5'd16) || (w[20:16] == 5'd17);
        end
        if (op == OP_SPECIAL) begin
            return (w[5:0] == FN_JR) || (w[5:0] == FN_JALR);
        end
        return 1'b0;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
        if (exp !== got) begin
            $display("ERR %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        $display("errors: %0d, instructions checked: %0d", errors, consumed);
        $display("Simulation failed");
        $finish;
    endtask

    // one accepted bundle against the sequential walk of prog
    task automatic checkTransfer();
        logic [INST_W-1:0] w0;
        logic [INST_W-1:0] w1;
        logic              c0;
        w0 = prog[expPc[7:2]];
        w1 = prog[expPc[7:2] + 6'd1];
        c0 = isCtl(w0);
        checkValue("issuePc0", expPc, issuePc0);
        checkValue("issueInst0", w0, issueInst0);
        checkValue("issueValid0", 32'd1, {31'd0, issueValid0});
        // a branch must leave together with its delay slot
        if (c0) begin
            checkValue("issueValid1", 32'd1, {31'd0, issueValid1});
        end
        if (issueValid1) begin
            checkValue("issuePc1", expPc + 32'd4, issuePc1);
            checkValue("issueInst1", w1, issueInst1);
            checkValue("issueIsDs1", {31'd0, c0}, {31'd0, issueIsDs1});
            if (isCtl(w1)) begin
                $display("branch or jump issued in slot 1 at pc %h", issuePc1);
                errors++;
            end
            expPc = expPc + 32'd8;
            consumed += 2;
        end else begin
            checkValue("issueIsDs1", 32'd0, {31'd0, issueIsDs1});
            expPc = expPc + 32'd4;
            consumed += 1;
        end
    endtask

    task automatic stepCycle(input int pct);
        @(posedge clk);
        issueReady <= ($unsigned($random(seed)) % 100) < pct;
        @(negedge clk);
        if (issueValid && issueReady) begin
            checkTransfer();
        end
    endtask

    task automatic consume(input int n, input int pct);
        int target;
        int cyc;
        target = consumed + n;
        cyc = 0;
        while (consumed < target && cyc < 2000) begin
            stepCycle(pct);
            cyc++;
        end
        @(posedge clk);
        issueReady <= 1'b0;
        if (consumed < target) begin
            timeoutFail("issued instructions");
        end
    endtask

    task automatic redirect(input logic [PC_W-1:0] pc);
        @(posedge clk);
        flush <= 1'b1;
        redirectPc <= pc;
        issueReady <= 1'b0;
        @(negedge clk);
        if (issueValid) begin
            $display("issueValid high during the flush cycle");
            errors++;
        end
        @(posedge clk);
        flush <= 1'b0;
        expPc = pc;
    endtask

    // ready held low until the buffer parks fetch
    task automatic stallBackend();
        int cyc;
        for (cyc = 0; cyc < 40; cyc++) begin
            @(negedge clk);
            if (issueValid) begin
                checkValue("issuePc0", expPc, issuePc0);
            end
        end
        cyc = 0;
        while (!(dut.buffer.pauseReq && !wbCyc) && cyc < 40) begin
            @(negedge clk);
            cyc++;
        end
        if (!(dut.buffer.pauseReq && !wbCyc)) begin
            timeoutFail("pauseReq high with the bus idle");
        end
        for (cyc = 0; cyc < 4; cyc++) begin
            @(negedge clk);
            if (wbCyc || !dut.buffer.pauseReq) begin
                $display("fetch restarted while the buffer was paused");
                errors++;
            end
        end
    endtask

    // keep the stream moving until a bus cycle sits in a wait state
    task automatic waitMemoryWait(input int pct);
        int cyc;
        cyc = 0;
        do begin
            stepCycle(pct);
            cyc++;
        end while (!(wbCyc && !wbAck) && cyc < 300);
        if (!(wbCyc && !wbAck)) begin
            timeoutFail("a memory wait state");
        end
    endtask

    initial begin
        seed = 32'h08868ab4;
        errors = 0;
        consumed = 0;
        busWait = 1'b0;
        lastAdr = '0;
        rst = 1'b1;
        flush = 1'b0;
        redirectPc = '0;
        issueReady = 1'b0;
        wbAck = 1'b0;
        wbDatIn = '0;

        // mostly addiu tagged with the word index
        for (int i = 0; i < 64; i++) begin
            prog[i] = 32'h2408_0000 + i;
        end
        prog[5] = 32'h1000_0004;
        prog[10] = 32'h0800_0020;
        prog[17] = 32'h03e0_0008;
        prog[23] = 32'h1085_fff0;
        prog[30] = 32'h0800_0001;
        prog[38] = 32'h0320_0008;
        prog[45] = 32'h1000_0003;
        prog[52] = 32'h0800_0010;
        prog[60] = 32'h03e0_0008;

        // start pc, count, ready %, hold ready low, end with flush in a wait
        rows[0] = '{RESET_PC, 40, 100, 1'b0, 1'b0};
        rows[1] = '{32'h0000_0014, 50, 60, 1'b0, 1'b1};
        rows[2] = '{32'h0000_0024, 60, 50, 1'b1, 1'b0};
        rows[3] = '{32'h0000_00e8, 40, 30, 1'b0, 1'b1};
        rows[4] = '{32'h0000_0028, 30, 100, 1'b0, 1'b0};

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("issueValid", 32'd0, {31'd0, issueValid});
        checkValue("pauseReq", 32'd0, {31'd0, dut.buffer.pauseReq});
        checkValue("wbCyc", 32'd0, {31'd0, wbCyc});

        for (r = 0; r < 5; r++) begin
            // the first row runs straight out of reset
            if (r == 0) begin
                expPc = rows[0].startPc;
            end else begin
                redirect(rows[r].startPc);
            end
            if (rows[r].holdReady) begin
                consume(rows[r].count / 2, rows[r].readyPct);
                stallBackend();
                consume(rows[r].count - rows[r].count / 2, rows[r].readyPct);
            end else begin
                consume(rows[r].count, rows[r].readyPct);
            end
            if (rows[r].endFlush) begin
                waitMemoryWait(rows[r].readyPct);
            end
        end

        $display("errors: %0d, instructions checked: %0d", errors, consumed);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- frontEnd.f
frontEndPkg.sv
preDecode.sv
fetchUnit.sv
instBuffer.sv
frontEnd.sv
frontEnd_tb.sv

//--- run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f frontEnd.f --top-module frontEnd_tb -o simFrontEnd

# the log decides the result, so a nonzero exit from the model is not fatal here
./obj_dir/simFrontEnd > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi
